/* common/lookup_pkg.sv */
/*
  Lookup packet path types
  Ethernet address, one-hot port set and header parser states
*/
`default_nettype none

`include "lookup_settings.svh"

package lookup_pkg;

  typedef logic [47:0] mac_addr_t;

  // One bit per output queue
  typedef logic [`NUM_QUEUES-1:0] port_t;

  // HEADER means the next accepted beat opens a packet
  typedef enum logic {
    HEADER  = 1'b0,
    PAYLOAD = 1'b1
  } parse_state_t;

endpackage

`default_nettype wire

/* common/lookup_settings.svh */
/*
  Output port lookup settings
  Stream widths, tuser port field positions, CAM depth and register bus widths
*/
`ifndef LOOKUP_SETTINGS_SVH
`define LOOKUP_SETTINGS_SVH

// AXI4-Stream datapath
`define DATA_WIDTH      256
`define TUSER_WIDTH     128

// One-hot port fields inside tuser
`define SRC_PORT_POS    16
`define DST_PORT_POS    24
`define NUM_QUEUES      8
`define PHYS_PORT_MASK  8'b01010101

`define CAM_DEPTH       16

// AXI4-Lite register bus
`define REG_DATA_WIDTH  32
`define REG_ADDR_WIDTH  32

`endif

/* common/regs_pkg.sv */
/*
  Register path types
  Register byte offsets and AXI response codes
*/
`default_nettype none

`include "lookup_settings.svh"

package regs_pkg;

  typedef enum logic [`REG_ADDR_WIDTH-1:0] {
    REG_CTRL     = 'h0,
    REG_HIT_CNT  = 'h4,
    REG_MISS_CNT = 'h8
  } reg_addr_t;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axi_resp_t;

endpackage

`default_nettype wire

/* filelist.f */
+incdir+common
common/lookup_pkg.sv
common/regs_pkg.sv
verilog/axi_lite_slave.sv
verilog/lookup_regs.sv
output_port_lookup/mac_cam.sv
output_port_lookup/output_port_lookup.sv
verilog/switch_output_port_lookup.sv
testbench/tb_switch_output_port_lookup.sv

/* output_port_lookup/mac_cam.sv */
/*
  MAC learning CAM
  Parallel match over all entries, in-place update and round-robin replacement
*/
`default_nettype none

`include "lookup_settings.svh"

module mac_cam
  import lookup_pkg::*;
(
  input  logic      clk,
  input  logic      resetn,
  input  mac_addr_t dst_mac,
  output logic      match,
  output port_t     match_port,
  input  logic      learn,
  input  mac_addr_t src_mac,
  input  port_t     src_port
);

  localparam int IDX_W = $clog2(`CAM_DEPTH);

  mac_addr_t             mac_tbl [`CAM_DEPTH];
  port_t                 port_tbl [`CAM_DEPTH];
  logic [`CAM_DEPTH-1:0] valid;
  logic [IDX_W-1:0]      wr_ptr;
  logic [IDX_W-1:0]      dst_idx;
  logic [IDX_W-1:0]      src_idx;
  logic                  src_hit;

  // Lowest valid entry holding this address
  function automatic void find_entry(input mac_addr_t mac, output logic hit,
                                     output logic [IDX_W-1:0] idx);
    hit = 1'b0;
    idx = '0;
    for (int i = 0; i < `CAM_DEPTH; i++) begin
      if (!hit && valid[i] && mac_tbl[i] == mac) begin
        hit = 1'b1;
        idx = IDX_W'(i);
      end
    end
  endfunction

  always_comb begin
    find_entry(dst_mac, match, dst_idx);
    find_entry(src_mac, src_hit, src_idx);
  end

  assign match_port = port_tbl[dst_idx];

  always_ff @(posedge clk) begin
    if (!resetn) begin
      valid  <= '0;
      wr_ptr <= '0;
    end else if (learn && !src_hit) begin
      valid[wr_ptr] <= 1'b1;
      wr_ptr        <= (wr_ptr == IDX_W'(`CAM_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
    end
  end

  // Known MAC moves to its new port, unknown MAC takes the oldest slot
  always_ff @(posedge clk) begin
    if (learn) begin
      if (src_hit) begin
        port_tbl[src_idx] <= src_port;
      end else begin
        mac_tbl[wr_ptr]  <= src_mac;
        port_tbl[wr_ptr] <= src_port;
      end
    end
  end

endmodule

`default_nettype wire

/* output_port_lookup/output_port_lookup.sv */
/*
  Output port lookup stage
  Learns the source MAC and writes the destination port field on each header beat
*/
`default_nettype none

`include "lookup_settings.svh"

module output_port_lookup
  import lookup_pkg::*;
(
  input  logic                     axi_aclk,
  input  logic                     axi_resetn,
  input  logic [`DATA_WIDTH-1:0]   s_axis_tdata,
  input  logic [`DATA_WIDTH/8-1:0] s_axis_tstrb,
  input  logic [`TUSER_WIDTH-1:0]  s_axis_tuser,
  input  logic                     s_axis_tvalid,
  output logic                     s_axis_tready,
  input  logic                     s_axis_tlast,
  output logic [`DATA_WIDTH-1:0]   m_axis_tdata,
  output logic [`DATA_WIDTH/8-1:0] m_axis_tstrb,
  output logic [`TUSER_WIDTH-1:0]  m_axis_tuser,
  output logic                     m_axis_tvalid,
  input  logic                     m_axis_tready,
  output logic                     m_axis_tlast,
  output logic                     lut_hit,
  output logic                     lut_miss
);

  parse_state_t              state;
  logic                      accept;
  logic                      is_header;
  logic                      mcast;
  logic                      match;
  mac_addr_t                 dst_mac;
  mac_addr_t                 src_mac;
  port_t                     src_port;
  port_t                     match_port;
  port_t                     dst_port;
  logic [`TUSER_WIDTH-1:0]   tuser_next;

  // One-beat pipeline register, refilled while it drains
  assign s_axis_tready = !m_axis_tvalid || m_axis_tready;
  assign accept        = s_axis_tvalid && s_axis_tready;
  assign is_header     = (state == HEADER);

  // Ethernet header sits at the bottom of the first beat
  assign dst_mac  = s_axis_tdata[47:0];
  assign src_mac  = s_axis_tdata[95:48];
  assign src_port = s_axis_tuser[`SRC_PORT_POS +: `NUM_QUEUES];
  assign mcast    = dst_mac[0];

  mac_cam u_mac_cam (
    .clk        (axi_aclk),
    .resetn     (axi_resetn),
    .dst_mac    (dst_mac),
    .match      (match),
    .match_port (match_port),
    .learn      (accept && is_header),
    .src_mac    (src_mac),
    .src_port   (src_port)
  );

  // Flood to every physical port except the one the packet came in on
  assign dst_port = (match && !mcast) ? match_port : (`PHYS_PORT_MASK & ~src_port);

  assign lut_hit  = accept && is_header && match && !mcast;
  assign lut_miss = accept && is_header && !(match && !mcast);

  always_comb begin
    tuser_next = s_axis_tuser;
    if (is_header) begin
      tuser_next[`DST_PORT_POS +: `NUM_QUEUES] = dst_port;
    end
  end

  always_ff @(posedge axi_aclk) begin
    if (!axi_resetn) begin
      state <= HEADER;
    end else if (accept) begin
      state <= s_axis_tlast ? HEADER : PAYLOAD;
    end
  end

  always_ff @(posedge axi_aclk) begin
    if (!axi_resetn) begin
      m_axis_tvalid <= 1'b0;
    end else if (accept) begin
      m_axis_tvalid <= 1'b1;
    end else if (m_axis_tready) begin
      m_axis_tvalid <= 1'b0;
    end
  end

  always_ff @(posedge axi_aclk) begin
    if (accept) begin
      m_axis_tdata <= s_axis_tdata;
      m_axis_tstrb <= s_axis_tstrb;
      m_axis_tuser <= tuser_next;
      m_axis_tlast <= s_axis_tlast;
    end
  end

endmodule

`default_nettype wire

/* testbench/tb_switch_output_port_lookup.sv */
/*
  Switch output port lookup testbench
  LFSR-driven packets and register accesses checked against a learning switch model
*/
`default_nettype none

`include "lookup_settings.svh"

module tb_switch_output_port_lookup
  import lookup_pkg::*, regs_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int PKTS_FIRST        = 160;
  localparam int PKTS_AFTER_CLEAR  = 40;
  localparam int MAX_BEATS         = 4;
  localparam int CYCLES_PER_BEAT   = 4;
  localparam int REG_ACCESSES      = 16;
  localparam int CYCLES_PER_ACCESS = 8;
  localparam int RESET_CYCLES      = 10;
  localparam int MAX_CYCLES = (PKTS_FIRST + PKTS_AFTER_CLEAR) * MAX_BEATS * CYCLES_PER_BEAT
                              + REG_ACCESSES * CYCLES_PER_ACCESS + RESET_CYCLES;

  localparam int T_RESET = 0;
  localparam int T_FWD   = 1;
  localparam int T_BEAT  = 2;
  localparam int T_ORDER = 3;
  localparam int T_COUNT = 4;
  localparam int T_CLEAR = 5;

  logic                       S_AXI_ACLK;
  logic                       S_AXI_ARESETN;
  logic [`REG_ADDR_WIDTH-1:0] S_AXI_AWADDR;
  logic                       S_AXI_AWVALID;
  logic [`REG_DATA_WIDTH-1:0] S_AXI_WDATA;
  logic                       S_AXI_WVALID;
  logic                       S_AXI_BREADY;
  logic [`REG_ADDR_WIDTH-1:0] S_AXI_ARADDR;
  logic                       S_AXI_ARVALID;
  logic                       S_AXI_RREADY;
  logic                       S_AXI_ARREADY;
  logic [`REG_DATA_WIDTH-1:0] S_AXI_RDATA;
  logic [1:0]                 S_AXI_RRESP;
  logic                       S_AXI_RVALID;
  logic                       S_AXI_WREADY;
  logic [1:0]                 S_AXI_BRESP;
  logic                       S_AXI_BVALID;
  logic                       S_AXI_AWREADY;
  logic [`DATA_WIDTH-1:0]     M_AXIS_TDATA;
  logic [`DATA_WIDTH/8-1:0]   M_AXIS_TSTRB;
  logic [`TUSER_WIDTH-1:0]    M_AXIS_TUSER;
  logic                       M_AXIS_TVALID;
  logic                       M_AXIS_TREADY;
  logic                       M_AXIS_TLAST;
  logic [`DATA_WIDTH-1:0]     S_AXIS_TDATA;
  logic [`DATA_WIDTH/8-1:0]   S_AXIS_TSTRB;
  logic [`TUSER_WIDTH-1:0]    S_AXIS_TUSER;
  logic                       S_AXIS_TVALID;
  logic                       S_AXIS_TREADY;
  logic                       S_AXIS_TLAST;

  logic [31:0] lfsr_state;
  int          cycle_count;
  string       test_name [6];
  int          check_count [6];
  int          error_count [6];
  int          fwd_test;
  int          beat_test;
  int          order_test;
  logic [1:0]  reg_resp;
  logic [31:0] reg_data;

  // Switch model state
  mac_addr_t mac_pool [6];
  mac_addr_t cam_mac [`CAM_DEPTH];
  port_t     cam_port [`CAM_DEPTH];
  logic      cam_valid [`CAM_DEPTH];
  int        cam_ptr;
  int        hit_count;
  int        miss_count;
  logic      model_at_header;

  // Packet source state
  int        beat_idx;
  int        pkt_len;
  int        pkts_driven;
  int        beats_in;
  int        beats_out;
  mac_addr_t pkt_dst;
  mac_addr_t pkt_src;
  port_t     pkt_src_port;

  logic [`DATA_WIDTH-1:0]   exp_data_q [$];
  logic [`DATA_WIDTH/8-1:0] exp_strb_q [$];
  logic [`TUSER_WIDTH-1:0]  exp_user_q [$];
  logic                     exp_last_q [$];

  switch_output_port_lookup u_switch_output_port_lookup (.*);

  always #10 S_AXI_ACLK = ~S_AXI_ACLK;

  always @(posedge S_AXI_ACLK) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout: run stopped after %0d cycles without finishing", cycle_count);
      $display("Test failed");
      $finish;
    end
  end

  // Galois LFSR, polynomial x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  function automatic logic [255:0] rand_bits(input int n);
    logic [255:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v[i] = lfsr_state[0];
      lfsr_state = lfsr_next(lfsr_state);
    end
    return v;
  endfunction

  task automatic check_value(input int test_id, input string what,
                             input logic [255:0] expected, input logic [255:0] actual);
    check_count[test_id]++;
    if (expected !== actual) begin
      error_count[test_id]++;
      $display("Mismatch %s (%s): expected %0h, actual %0h",
               test_name[test_id], what, expected, actual);
    end
  endtask

  task automatic report_test(input int test_id);
    $display("%s: %0d checks, %0d errors",
             test_name[test_id], check_count[test_id], error_count[test_id]);
  endtask

  // Lowest valid entry wins, as in a priority match
  function automatic int cam_find(input mac_addr_t mac);
    for (int i = 0; i < `CAM_DEPTH; i++) begin
      if (cam_valid[i] && cam_mac[i] == mac) begin
        return i;
      end
    end
    return -1;
  endfunction

  task automatic cam_learn(input mac_addr_t mac, input port_t port);
    int idx;
    idx = cam_find(mac);
    if (idx >= 0) begin
      cam_port[idx] = port;
    end else begin
      cam_mac[cam_ptr]   = mac;
      cam_port[cam_ptr]  = port;
      cam_valid[cam_ptr] = 1'b1;
      cam_ptr = (cam_ptr + 1) % `CAM_DEPTH;
    end
  endtask

  // Called before the edge that accepts the beat on S_AXIS
  task automatic model_accept();
    logic [`TUSER_WIDTH-1:0] user;
    int                      idx;
    port_t                   src;
    port_t                   dst;
    user = S_AXIS_TUSER;
    if (model_at_header) begin
      idx = cam_find(S_AXIS_TDATA[47:0]);
      src = S_AXIS_TUSER[`SRC_PORT_POS +: `NUM_QUEUES];
      if (idx >= 0 && !S_AXIS_TDATA[0]) begin
        dst = cam_port[idx];
        hit_count++;
      end else begin
        dst = `PHYS_PORT_MASK & ~src;
        miss_count++;
      end
      user[`DST_PORT_POS +: `NUM_QUEUES] = dst;
      cam_learn(S_AXIS_TDATA[95:48], src);
    end
    model_at_header = S_AXIS_TLAST;
    exp_data_q.push_back(S_AXIS_TDATA);
    exp_strb_q.push_back(S_AXIS_TSTRB);
    exp_user_q.push_back(user);
    exp_last_q.push_back(S_AXIS_TLAST);
    beats_in++;
  endtask

  task automatic compare_output();
    logic [`TUSER_WIDTH-1:0] exp_user;
    logic [`TUSER_WIDTH-1:0] act_user;
    beats_out++;
    if (exp_data_q.size() == 0) begin
      check_count[order_test]++;
      error_count[order_test]++;
      $display("%s: an output beat appeared with no beat expected", test_name[order_test]);
    end else begin
      exp_user = exp_user_q.pop_front();
      act_user = M_AXIS_TUSER;
      check_value(fwd_test, "tuser port field", exp_user[`DST_PORT_POS +: `NUM_QUEUES],
                  act_user[`DST_PORT_POS +: `NUM_QUEUES]);
      check_value(beat_test, "tdata", exp_data_q.pop_front(), M_AXIS_TDATA);
      check_value(beat_test, "tstrb", exp_strb_q.pop_front(), M_AXIS_TSTRB);
      check_value(beat_test, "tlast", exp_last_q.pop_front(), M_AXIS_TLAST);
      exp_user[`DST_PORT_POS +: `NUM_QUEUES] = '0;
      act_user[`DST_PORT_POS +: `NUM_QUEUES] = '0;
      check_value(beat_test, "tuser", exp_user, act_user);
    end
  endtask

  task automatic drive_next_beat();
    logic [`DATA_WIDTH-1:0]  data;
    logic [`TUSER_WIDTH-1:0] user;
    if (beat_idx == 0) begin
      pkt_len      = int'(rand_bits(2)) + 1;
      pkt_dst      = mac_pool[int'(rand_bits(3) % 6)];
      pkt_src      = mac_pool[int'(rand_bits(3) % 6)];
      pkt_src_port = port_t'(1 << (2 * int'(rand_bits(2))));
    end
    data = rand_bits(`DATA_WIDTH);
    user = rand_bits(`TUSER_WIDTH);
    user[`SRC_PORT_POS +: `NUM_QUEUES] = pkt_src_port;
    if (beat_idx == 0) begin
      data[47:0]  = pkt_dst;
      data[95:48] = pkt_src;
    end
    S_AXIS_TDATA  = data;
    S_AXIS_TSTRB  = rand_bits(`DATA_WIDTH / 8);
    S_AXIS_TUSER  = user;
    S_AXIS_TLAST  = (beat_idx == pkt_len - 1);
    S_AXIS_TVALID = 1'b1;
    beat_idx = (beat_idx == pkt_len - 1) ? 0 : beat_idx + 1;
    if (beat_idx == 0) begin
      pkts_driven++;
    end
  endtask

  // Handshakes are sampled at the falling edge, inputs change 2 ns after the rising edge
  task automatic run_stream(input int num_pkts);
    logic accepted;
    logic done;
    pkts_driven = 0;
    beat_idx    = 0;
    done        = 1'b0;
    @(posedge S_AXI_ACLK);
    #2;
    drive_next_beat();
    M_AXIS_TREADY = (rand_bits(2) != 0);
    while (!done) begin
      @(negedge S_AXI_ACLK);
      if (M_AXIS_TVALID && M_AXIS_TREADY) begin
        compare_output();
      end
      accepted = S_AXIS_TVALID && S_AXIS_TREADY;
      if (accepted) begin
        model_accept();
      end
      @(posedge S_AXI_ACLK);
      #2;
      M_AXIS_TREADY = (rand_bits(2) != 0);
      if (accepted) begin
        if (pkts_driven < num_pkts) begin
          drive_next_beat();
        end else begin
          S_AXIS_TVALID = 1'b0;
        end
      end
      done = !S_AXIS_TVALID && !M_AXIS_TVALID && (exp_data_q.size() == 0);
    end
    M_AXIS_TREADY = 1'b1;
  endtask

  // BREADY and RREADY stay high, so each response completes on the edge after it shows
  task automatic reg_write(input int test_id, input logic [31:0] addr,
                           input logic [31:0] data, output logic [1:0] resp);
    @(posedge S_AXI_ACLK);
    #2;
    S_AXI_AWADDR  = addr;
    S_AXI_WDATA   = data;
    S_AXI_AWVALID = 1'b1;
    S_AXI_WVALID  = 1'b1;
    @(negedge S_AXI_ACLK);
    while (!S_AXI_AWREADY) @(negedge S_AXI_ACLK);
    // Address and data channels complete on the same edge
    check_value(test_id, "wready with awready", 1'b1, S_AXI_WREADY);
    @(posedge S_AXI_ACLK);
    #2;
    S_AXI_AWVALID = 1'b0;
    S_AXI_WVALID  = 1'b0;
    @(negedge S_AXI_ACLK);
    while (!S_AXI_BVALID) @(negedge S_AXI_ACLK);
    resp = S_AXI_BRESP;
    @(posedge S_AXI_ACLK);
  endtask

  task automatic reg_read(input logic [31:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
    @(posedge S_AXI_ACLK);
    #2;
    S_AXI_ARADDR  = addr;
    S_AXI_ARVALID = 1'b1;
    @(negedge S_AXI_ACLK);
    while (!S_AXI_ARREADY) @(negedge S_AXI_ACLK);
    @(posedge S_AXI_ACLK);
    #2;
    S_AXI_ARVALID = 1'b0;
    @(negedge S_AXI_ACLK);
    while (!S_AXI_RVALID) @(negedge S_AXI_ACLK);
    data = S_AXI_RDATA;
    resp = S_AXI_RRESP;
    @(posedge S_AXI_ACLK);
  endtask

  task automatic expect_read(input int test_id, input string what, input logic [31:0] addr,
                             input logic [31:0] exp_data, input logic [1:0] exp_resp);
    reg_read(addr, reg_data, reg_resp);
    check_value(test_id, {what, " data"}, exp_data, reg_data);
    check_value(test_id, {what, " response"}, exp_resp, reg_resp);
  endtask

  task automatic expect_write(input int test_id, input string what, input logic [31:0] addr,
                              input logic [31:0] data, input logic [1:0] exp_resp);
    reg_write(test_id, addr, data, reg_resp);
    check_value(test_id, {what, " response"}, exp_resp, reg_resp);
  endtask

  initial begin
    S_AXI_ACLK    = 1'b0;
    S_AXI_ARESETN = 1'b0;
    S_AXI_AWADDR  = '0;
    S_AXI_AWVALID = 1'b0;
    S_AXI_WDATA   = '0;
    S_AXI_WVALID  = 1'b0;
    S_AXI_BREADY  = 1'b1;
    S_AXI_ARADDR  = '0;
    S_AXI_ARVALID = 1'b0;
    S_AXI_RREADY  = 1'b1;
    M_AXIS_TREADY = 1'b1;
    S_AXIS_TDATA  = '0;
    S_AXIS_TSTRB  = '0;
    S_AXIS_TUSER  = '0;
    S_AXIS_TVALID = 1'b0;
    S_AXIS_TLAST  = 1'b0;
    lfsr_state    = 32'h68e6;
    cycle_count   = 0;
    test_name     = '{"reset_regs", "forwarding", "beat_fields", "ordering", "counters",
                      "counter_clear"};
    for (int i = 0; i < 6; i++) begin
      check_count[i] = 0;
      error_count[i] = 0;
    end
    // Five unicast addresses and broadcast
    mac_pool = '{48'h02a0_c900_1000, 48'h02a0_c900_2000, 48'h02a0_c900_3000,
                 48'h02a0_c900_4000, 48'h02a0_c900_5000, 48'hffff_ffff_ffff};
    for (int i = 0; i < `CAM_DEPTH; i++) begin
      cam_valid[i] = 1'b0;
    end
    cam_ptr         = 0;
    hit_count       = 0;
    miss_count      = 0;
    beats_in        = 0;
    beats_out       = 0;
    model_at_header = 1'b1;

    repeat (RESET_CYCLES) @(posedge S_AXI_ACLK);
    #2;
    S_AXI_ARESETN = 1'b1;

    expect_read(T_RESET, "ctrl", REG_CTRL, 0, RESP_OKAY);
    expect_read(T_RESET, "hit counter", REG_HIT_CNT, 0, RESP_OKAY);
    expect_read(T_RESET, "miss counter", REG_MISS_CNT, 0, RESP_OKAY);
    expect_read(T_RESET, "unmapped read", 32'hc, 0, RESP_SLVERR);
    expect_write(T_RESET, "hit counter write", REG_HIT_CNT, 32'h5, RESP_SLVERR);
    report_test(T_RESET);

    fwd_test   = T_FWD;
    beat_test  = T_BEAT;
    order_test = T_ORDER;
    run_stream(PKTS_FIRST);
    check_value(T_ORDER, "beat count", beats_in, beats_out);
    report_test(T_FWD);
    report_test(T_BEAT);
    report_test(T_ORDER);

    expect_read(T_COUNT, "hit counter", REG_HIT_CNT, hit_count, RESP_OKAY);
    expect_read(T_COUNT, "miss counter", REG_MISS_CNT, miss_count, RESP_OKAY);
    report_test(T_COUNT);

    // Pulse the clear bit, then count a fresh stream against the same CAM
    expect_write(T_CLEAR, "clear set", REG_CTRL, 1, RESP_OKAY);
    expect_read(T_CLEAR, "ctrl", REG_CTRL, 1, RESP_OKAY);
    expect_write(T_CLEAR, "clear release", REG_CTRL, 0, RESP_OKAY);
    expect_read(T_CLEAR, "cleared hit counter", REG_HIT_CNT, 0, RESP_OKAY);
    expect_read(T_CLEAR, "cleared miss counter", REG_MISS_CNT, 0, RESP_OKAY);
    hit_count  = 0;
    miss_count = 0;
    beats_in   = 0;
    beats_out  = 0;
    fwd_test   = T_CLEAR;
    beat_test  = T_CLEAR;
    order_test = T_CLEAR;
    run_stream(PKTS_AFTER_CLEAR);
    check_value(T_CLEAR, "beat count", beats_in, beats_out);
    expect_read(T_CLEAR, "hit counter", REG_HIT_CNT, hit_count, RESP_OKAY);
    expect_read(T_CLEAR, "miss counter", REG_MISS_CNT, miss_count, RESP_OKAY);
    report_test(T_CLEAR);

    $display("Totals: %0d checks, %0d errors",
             check_count.sum(), error_count.sum());
    if (error_count.sum() == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/axi_lite_slave.sv */
/*
  AXI4-Lite slave
  Turns bus transactions into single-cycle register strobes, one outstanding per channel
*/
`default_nettype none

`include "lookup_settings.svh"

module axi_lite_slave
  import regs_pkg::*;
(
  input  logic                       s_axi_aclk,
  input  logic                       s_axi_aresetn,
  input  logic [`REG_ADDR_WIDTH-1:0] awaddr,
  input  logic                       awvalid,
  output logic                       awready,
  input  logic [`REG_DATA_WIDTH-1:0] wdata,
  input  logic                       wvalid,
  output logic                       wready,
  output axi_resp_t                  bresp,
  output logic                       bvalid,
  input  logic                       bready,
  input  logic [`REG_ADDR_WIDTH-1:0] araddr,
  input  logic                       arvalid,
  output logic                       arready,
  output logic [`REG_DATA_WIDTH-1:0] rdata,
  output axi_resp_t                  rresp,
  output logic                       rvalid,
  input  logic                       rready,
  output logic                       reg_wr,
  output logic                       reg_rd,
  output logic [`REG_ADDR_WIDTH-1:0] reg_addr,
  output logic [`REG_DATA_WIDTH-1:0] reg_wdata,
  input  logic [`REG_DATA_WIDTH-1:0] reg_rdata,
  input  logic                       reg_err
);

  logic wr_start;
  logic rd_start;

  // Write wins when both channels start together, so the strobes never overlap
  assign wr_start = awvalid && wvalid && !bvalid && !awready;
  assign rd_start = arvalid && !rvalid && !arready && !wr_start;

  // Address and data are accepted in the same cycle
  assign wready    = awready;
  assign reg_wr    = awready;
  assign reg_rd    = arready;
  assign reg_addr  = awready ? awaddr : araddr;
  assign reg_wdata = wdata;

  always_ff @(posedge s_axi_aclk) begin
    if (!s_axi_aresetn) begin
      awready <= 1'b0;
      bvalid  <= 1'b0;
    end else begin
      awready <= wr_start;
      if (awready) begin
        bvalid <= 1'b1;
      end else if (bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge s_axi_aclk) begin
    if (!s_axi_aresetn) begin
      arready <= 1'b0;
      rvalid  <= 1'b0;
    end else begin
      arready <= rd_start;
      if (arready) begin
        rvalid <= 1'b1;
      end else if (rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  // Response payload captured on the strobe cycle
  always_ff @(posedge s_axi_aclk) begin
    if (awready) begin
      bresp <= reg_err ? RESP_SLVERR : RESP_OKAY;
    end
    if (arready) begin
      rdata <= reg_rdata;
      rresp <= reg_err ? RESP_SLVERR : RESP_OKAY;
    end
  end

endmodule

`default_nettype wire

/* verilog/lookup_regs.sv */
/*
  Lookup register file
  Counter clear control bit plus the wrapping hit and miss counters
*/
`default_nettype none

`include "lookup_settings.svh"

module lookup_regs
  import regs_pkg::*;
(
  input  logic                       clk,
  input  logic                       resetn,
  input  logic                       reg_wr,
  input  logic                       reg_rd,
  input  logic [`REG_ADDR_WIDTH-1:0] reg_addr,
  input  logic [`REG_DATA_WIDTH-1:0] reg_wdata,
  output logic [`REG_DATA_WIDTH-1:0] reg_rdata,
  output logic                       reg_err,
  input  logic                       lut_hit,
  input  logic                       lut_miss
);

  reg_addr_t                  addr;
  logic                       mapped;
  logic                       writable;
  logic                       clr_cntrs;
  logic [`REG_DATA_WIDTH-1:0] hit_cnt;
  logic [`REG_DATA_WIDTH-1:0] miss_cnt;

  assign addr = reg_addr_t'(reg_addr);

  always_comb begin
    mapped    = 1'b1;
    writable  = 1'b0;
    reg_rdata = '0;
    case (addr)
      REG_CTRL: begin
        writable  = 1'b1;
        reg_rdata = {{(`REG_DATA_WIDTH-1){1'b0}}, clr_cntrs};
      end
      REG_HIT_CNT:  reg_rdata = hit_cnt;
      REG_MISS_CNT: reg_rdata = miss_cnt;
      default:      mapped = 1'b0;
    endcase
  end

  // Unmapped reads, and writes anywhere but the control word
  assign reg_err = (reg_rd && !mapped) || (reg_wr && !writable);

  always_ff @(posedge clk) begin
    if (!resetn) begin
      clr_cntrs <= 1'b0;
    end else if (reg_wr && writable) begin
      clr_cntrs <= reg_wdata[0];
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      hit_cnt  <= '0;
      miss_cnt <= '0;
    end else if (clr_cntrs) begin
      hit_cnt  <= '0;
      miss_cnt <= '0;
    end else begin
      if (lut_hit) begin
        hit_cnt <= hit_cnt + 1'b1;
      end
      if (lut_miss) begin
        miss_cnt <= miss_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/switch_output_port_lookup.sv */
/*
  Switch output port lookup wrapper
  Joins the AXI4-Lite slave, the counter registers and the learning lookup stage
*/
`default_nettype none

`include "lookup_settings.svh"

module switch_output_port_lookup (
  input  logic                         S_AXI_ACLK,
  input  logic                         S_AXI_ARESETN,
  input  logic [`REG_ADDR_WIDTH-1:0]   S_AXI_AWADDR,
  input  logic                         S_AXI_AWVALID,
  input  logic [`REG_DATA_WIDTH-1:0]   S_AXI_WDATA,
  input  logic                         S_AXI_WVALID,
  input  logic                         S_AXI_BREADY,
  input  logic [`REG_ADDR_WIDTH-1:0]   S_AXI_ARADDR,
  input  logic                         S_AXI_ARVALID,
  input  logic                         S_AXI_RREADY,
  output logic                         S_AXI_ARREADY,
  output logic [`REG_DATA_WIDTH-1:0]   S_AXI_RDATA,
  output logic [1:0]                   S_AXI_RRESP,
  output logic                         S_AXI_RVALID,
  output logic                         S_AXI_WREADY,
  output logic [1:0]                   S_AXI_BRESP,
  output logic                         S_AXI_BVALID,
  output logic                         S_AXI_AWREADY,

  // Master stream towards the output queues
  output logic [`DATA_WIDTH-1:0]       M_AXIS_TDATA,
  output logic [`DATA_WIDTH/8-1:0]     M_AXIS_TSTRB,
  output logic [`TUSER_WIDTH-1:0]      M_AXIS_TUSER,
  output logic                         M_AXIS_TVALID,
  input  logic                         M_AXIS_TREADY,
  output logic                         M_AXIS_TLAST,

  // Slave stream from the input arbiter
  input  logic [`DATA_WIDTH-1:0]       S_AXIS_TDATA,
  input  logic [`DATA_WIDTH/8-1:0]     S_AXIS_TSTRB,
  input  logic [`TUSER_WIDTH-1:0]      S_AXIS_TUSER,
  input  logic                         S_AXIS_TVALID,
  output logic                         S_AXIS_TREADY,
  input  logic                         S_AXIS_TLAST
);

  logic                       reg_wr;
  logic                       reg_rd;
  logic [`REG_ADDR_WIDTH-1:0] reg_addr;
  logic [`REG_DATA_WIDTH-1:0] reg_wdata;
  logic [`REG_DATA_WIDTH-1:0] reg_rdata;
  logic                       reg_err;
  logic                       lut_hit;
  logic                       lut_miss;

  axi_lite_slave u_axi_lite_slave (
    .s_axi_aclk    (S_AXI_ACLK),
    .s_axi_aresetn (S_AXI_ARESETN),
    .awaddr        (S_AXI_AWADDR),
    .awvalid       (S_AXI_AWVALID),
    .awready       (S_AXI_AWREADY),
    .wdata         (S_AXI_WDATA),
    .wvalid        (S_AXI_WVALID),
    .wready        (S_AXI_WREADY),
    .bresp         (S_AXI_BRESP),
    .bvalid        (S_AXI_BVALID),
    .bready        (S_AXI_BREADY),
    .araddr        (S_AXI_ARADDR),
    .arvalid       (S_AXI_ARVALID),
    .arready       (S_AXI_ARREADY),
    .rdata         (S_AXI_RDATA),
    .rresp         (S_AXI_RRESP),
    .rvalid        (S_AXI_RVALID),
    .rready        (S_AXI_RREADY),
    .reg_wr        (reg_wr),
    .reg_rd        (reg_rd),
    .reg_addr      (reg_addr),
    .reg_wdata     (reg_wdata),
    .reg_rdata     (reg_rdata),
    .reg_err       (reg_err)
  );

  lookup_regs u_lookup_regs (
    .clk       (S_AXI_ACLK),
    .resetn    (S_AXI_ARESETN),
    .reg_wr    (reg_wr),
    .reg_rd    (reg_rd),
    .reg_addr  (reg_addr),
    .reg_wdata (reg_wdata),
    .reg_rdata (reg_rdata),
    .reg_err   (reg_err),
    .lut_hit   (lut_hit),
    .lut_miss  (lut_miss)
  );

  output_port_lookup u_output_port_lookup (
    .axi_aclk      (S_AXI_ACLK),
    .axi_resetn    (S_AXI_ARESETN),
    .s_axis_tdata  (S_AXIS_TDATA),
    .s_axis_tstrb  (S_AXIS_TSTRB),
    .s_axis_tuser  (S_AXIS_TUSER),
    .s_axis_tvalid (S_AXIS_TVALID),
    .s_axis_tready (S_AXIS_TREADY),
    .s_axis_tlast  (S_AXIS_TLAST),
    .m_axis_tdata  (M_AXIS_TDATA),
    .m_axis_tstrb  (M_AXIS_TSTRB),
    .m_axis_tuser  (M_AXIS_TUSER),
    .m_axis_tvalid (M_AXIS_TVALID),
    .m_axis_tready (M_AXIS_TREADY),
    .m_axis_tlast  (M_AXIS_TLAST),
    .lut_hit       (lut_hit),
    .lut_miss      (lut_miss)
  );

endmodule

`default_nettype wire
